//--- card_pkg.sv
package card_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////

    // Twelve cards at addresses 1 to 12, address 0 unused
    localparam int NUM_CARDS   = 12;
    localparam int NUM_PAIRS   = NUM_CARDS / 2;
    localparam int FIRST_CARD  = 1;
    localparam int CARD_ADDR_W = 4;

    // Record layout {image[13:2], state[1:0]}
    localparam int IMAGE_W     = 12;
    localparam int RECORD_W    = IMAGE_W + 2;

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        CARD_HIDDEN  = 2'd0,
        CARD_SHOWN   = 2'd1,
        CARD_MATCHED = 2'd2
    } card_state_t;

    // Flip FSM, pick -> read -> compare -> resolve
    typedef enum logic [2:0] {
        IDLE,
        READ_FIRST,
        WAIT_SECOND,
        READ_SECOND,
        RESOLVE_A,
        RESOLVE_B
    } flip_state_t;

    // One image code per pair, all distinct
    localparam logic [IMAGE_W-1:0] CARD_IMAGES [NUM_PAIRS] = '{
        12'h1a3, 12'h2c5, 12'h3e7, 12'h4b9, 12'h5d1, 12'h6f2
    };

endpackage

//--- card_regfile_ctl.sv
`timescale 1ns/10ps

module card_regfile_ctl (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              check,
    input  logic [card_pkg::CARD_ADDR_W-1:0]  one_addr,
    input  logic                              wr1_en,
    input  logic [card_pkg::CARD_ADDR_W-1:0]  wr1_addr,
    input  logic [card_pkg::IMAGE_W-1:0]      wr1_image,
    input  card_pkg::card_state_t             wr1_state,
    input  logic                              wr2_en,
    input  logic [card_pkg::CARD_ADDR_W-1:0]  wr2_addr,
    input  card_pkg::card_state_t             wr2_state,
    output logic                              rf_wen_full,
    output logic                              rf_wen_state,
    output logic [card_pkg::CARD_ADDR_W-1:0]  rf_waddr,
    output logic [card_pkg::RECORD_W-1:0]     rf_wdata,
    output logic [card_pkg::CARD_ADDR_W-1:0]  rf_raddr,
    output logic                              sweep_busy
);
    import card_pkg::*;

    typedef enum logic {
        SINGLE,
        SWEEP
    } rd_mode_t;

    // One past the last card ends the sweep
    localparam logic [CARD_ADDR_W-1:0] SWEEP_END = CARD_ADDR_W'(NUM_CARDS + FIRST_CARD);

    rd_mode_t                 mode, mode_nxt;
    logic [CARD_ADDR_W-1:0]   raddr_nxt;

    //////////////////////////////////////////////////
    // Read address sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            mode     <= SINGLE;
            rf_raddr <= '0;
        end else begin
            mode     <= mode_nxt;
            rf_raddr <= raddr_nxt;
        end
    end

    always_comb begin
        mode_nxt  = mode;
        raddr_nxt = one_addr;
        case (mode)
            SINGLE: begin
                // Check starts a sweep from card 1
                if (check) begin
                    mode_nxt  = SWEEP;
                    raddr_nxt = CARD_ADDR_W'(FIRST_CARD);
                end
            end
            SWEEP: begin
                // Check is ignored here
                if (rf_raddr == SWEEP_END) begin
                    mode_nxt = SINGLE;
                end else begin
                    raddr_nxt = rf_raddr + 1'b1;
                end
            end
            default: mode_nxt = SINGLE;
        endcase
    end

    assign sweep_busy = (mode == SWEEP);

    //////////////////////////////////////////////////
    // Write port mux, dealer has priority
    //////////////////////////////////////////////////

    assign rf_wen_full  = wr1_en;
    assign rf_wen_state = wr2_en & ~wr1_en;

    assign rf_waddr = wr1_en ? wr1_addr :
                      wr2_en ? wr2_addr : '0;

    // State-only write leaves image bits zero, regfile ignores them
    assign rf_wdata = wr1_en ? {wr1_image, wr1_state} :
                      wr2_en ? {{IMAGE_W{1'b0}}, wr2_state} : '0;

endmodule

//--- card_regfile.sv
`timescale 1ns/10ps

module card_regfile (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              wen_full,
    input  logic                              wen_state,
    input  logic [card_pkg::CARD_ADDR_W-1:0]  waddr,
    input  logic [card_pkg::RECORD_W-1:0]     wdata,
    input  logic [card_pkg::CARD_ADDR_W-1:0]  raddr,
    output logic [card_pkg::RECORD_W-1:0]     rdata
);
    import card_pkg::*;

    // Entries 1..12, address 0 has no storage
    logic [RECORD_W-1:0] mem [FIRST_CARD:NUM_CARDS];
    logic                waddr_ok;
    logic                raddr_ok;

    assign waddr_ok = (waddr >= CARD_ADDR_W'(FIRST_CARD)) &&
                      (waddr <= CARD_ADDR_W'(NUM_CARDS));
    assign raddr_ok = (raddr >= CARD_ADDR_W'(FIRST_CARD)) &&
                      (raddr <= CARD_ADDR_W'(NUM_CARDS));

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = FIRST_CARD; i <= NUM_CARDS; i++) begin
                mem[i] <= '0;
            end
        end else if (waddr_ok) begin
            if (wen_full) begin
                mem[waddr] <= wdata;
            end else if (wen_state) begin
                // Only the state bits change
                mem[waddr][1:0] <= wdata[1:0];
            end
        end
    end

    // Combinational read, zero outside the card range
    assign rdata = raddr_ok ? mem[raddr] : '0;

endmodule

//--- card_dealer.sv
`timescale 1ns/10ps

module card_dealer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              deal,
    input  logic [card_pkg::CARD_ADDR_W-1:0]  deal_seed,
    output logic                              wr1_en,
    output logic [card_pkg::CARD_ADDR_W-1:0]  wr1_addr,
    output logic [card_pkg::IMAGE_W-1:0]      wr1_image,
    output card_pkg::card_state_t             wr1_state,
    output logic                              deal_busy
);
    import card_pkg::*;

    localparam logic [CARD_ADDR_W-1:0] LAST_CARD = CARD_ADDR_W'(NUM_CARDS);
    localparam logic [CARD_ADDR_W-1:0] LAST_SLOT = CARD_ADDR_W'(NUM_CARDS - 1);

    logic [CARD_ADDR_W-1:0]       pos;
    // Rotated slot, (k-1+seed) mod 12
    logic [CARD_ADDR_W-1:0]       rot;
    logic [CARD_ADDR_W-1:0]       seed_mod;
    logic [$clog2(NUM_PAIRS)-1:0] pair_idx;

    // Seed is 0..15, fold into 0..11
    assign seed_mod = (deal_seed >= LAST_CARD) ? deal_seed - LAST_CARD : deal_seed;

    //////////////////////////////////////////////////
    // Position and rotation counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            deal_busy <= 1'b0;
            pos       <= '0;
            rot       <= '0;
        end else if (!deal_busy) begin
            // Seed sampled with the strobe
            if (deal) begin
                deal_busy <= 1'b1;
                pos       <= CARD_ADDR_W'(FIRST_CARD);
                rot       <= seed_mod;
            end
        end else begin
            pos <= pos + 1'b1;
            rot <= (rot == LAST_SLOT) ? '0 : rot + 1'b1;
            // Twelfth card goes out this cycle
            if (pos == LAST_CARD) begin
                deal_busy <= 1'b0;
            end
        end
    end

    // Two consecutive slots share a pair
    assign pair_idx  = rot[CARD_ADDR_W-1:1];

    // One record per busy cycle
    assign wr1_en    = deal_busy;
    assign wr1_addr  = pos;
    assign wr1_image = CARD_IMAGES[pair_idx];
    assign wr1_state = CARD_HIDDEN;

endmodule

//--- card_flip_logic.sv
`timescale 1ns/10ps

module card_flip_logic (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              pick,
    input  logic [card_pkg::CARD_ADDR_W-1:0]  pick_addr,
    input  logic                              deal_busy,
    input  logic                              sweep_busy,
    input  logic [card_pkg::RECORD_W-1:0]     rd_data,
    output logic [card_pkg::CARD_ADDR_W-1:0]  one_addr,
    output logic                              wr2_en,
    output logic [card_pkg::CARD_ADDR_W-1:0]  wr2_addr,
    output card_pkg::card_state_t             wr2_state,
    output logic                              flip_busy,
    output logic                              match,
    output logic                              miss
);
    import card_pkg::*;

    flip_state_t            state;
    // High for the cycle the ctl needs to load one_addr
    logic                   settle;
    logic [CARD_ADDR_W-1:0] first_addr;
    logic [IMAGE_W-1:0]     first_image;
    logic                   same_image;
    logic                   pick_ok;
    logic                   rd_ready;
    logic                   rd_hidden;
    logic [IMAGE_W-1:0]     rd_image;
    card_state_t            result;

    assign pick_ok   = pick && !flip_busy && !deal_busy && !sweep_busy;
    // Data is stale while a sweep owns the read address
    assign rd_ready  = !settle && !sweep_busy;
    assign rd_hidden = (card_state_t'(rd_data[1:0]) == CARD_HIDDEN);
    assign rd_image  = rd_data[RECORD_W-1:2];
    assign result    = same_image ? CARD_MATCHED : CARD_HIDDEN;

    //////////////////////////////////////////////////
    // Flip FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            one_addr  <= '0;
            settle    <= 1'b0;
            flip_busy <= 1'b0;
            wr2_en    <= 1'b0;
            match     <= 1'b0;
            miss      <= 1'b0;
        end else begin
            // Pulses by default
            settle <= 1'b0;
            wr2_en <= 1'b0;
            match  <= 1'b0;
            miss   <= 1'b0;
            case (state)
                IDLE, WAIT_SECOND: begin
                    if (pick_ok) begin
                        one_addr  <= pick_addr;
                        settle    <= 1'b1;
                        flip_busy <= 1'b1;
                        state     <= (state == IDLE) ? READ_FIRST : READ_SECOND;
                    end
                end
                READ_FIRST: begin
                    if (rd_ready) begin
                        flip_busy <= 1'b0;
                        // Face-up or matched card, drop the pick
                        if (rd_hidden) begin
                            wr2_en <= 1'b1;
                            state  <= WAIT_SECOND;
                        end else begin
                            state  <= IDLE;
                        end
                    end
                end
                READ_SECOND: begin
                    if (rd_ready) begin
                        if (rd_hidden) begin
                            state <= RESOLVE_A;
                        end else begin
                            // Keep the first card, wait again
                            flip_busy <= 1'b0;
                            state     <= WAIT_SECOND;
                        end
                    end
                end
                RESOLVE_A: begin
                    wr2_en <= 1'b1;
                    state  <= RESOLVE_B;
                end
                RESOLVE_B: begin
                    wr2_en    <= 1'b1;
                    match     <= same_image;
                    miss      <= !same_image;
                    flip_busy <= 1'b0;
                    state     <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Card payload and write data
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        case (state)
            READ_FIRST: begin
                first_addr  <= one_addr;
                first_image <= rd_image;
                wr2_addr    <= one_addr;
                wr2_state   <= CARD_SHOWN;
            end
            READ_SECOND: same_image <= (rd_image == first_image);
            // First card, then the second
            RESOLVE_A: begin
                wr2_addr  <= first_addr;
                wr2_state <= result;
            end
            RESOLVE_B: begin
                wr2_addr  <= one_addr;
                wr2_state <= result;
            end
            default: ;
        endcase
    end

endmodule

//--- card_scan.sv
`timescale 1ns/10ps

module card_scan (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              sweep_busy,
    input  logic [card_pkg::RECORD_W-1:0]     rd_data,
    output logic [card_pkg::CARD_ADDR_W-1:0]  matched_count,
    output logic                              all_matched,
    output logic                              check_done
);
    import card_pkg::*;

    logic                   sweep_d;
    logic [CARD_ADDR_W-1:0] count;
    logic                   is_matched;
    logic                   sweep_start;
    logic                   sweep_end;

    // Address 13 reads zero, never counted
    assign is_matched  = (card_state_t'(rd_data[1:0]) == CARD_MATCHED);
    assign sweep_start = sweep_busy && !sweep_d;
    assign sweep_end   = !sweep_busy && sweep_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_d       <= 1'b0;
            count         <= '0;
            matched_count <= '0;
            all_matched   <= 1'b0;
            check_done    <= 1'b0;
        end else begin
            sweep_d    <= sweep_busy;
            check_done <= 1'b0;

            //////////////////////////////////////////////////
            // Running count, card 1 arrives with the start
            //////////////////////////////////////////////////
            if (sweep_start) begin
                count <= CARD_ADDR_W'(is_matched);
            end else if (sweep_busy) begin
                count <= count + CARD_ADDR_W'(is_matched);
            end

            // Latch the result once the sweep is over
            if (sweep_end) begin
                matched_count <= count;
                all_matched   <= (count == CARD_ADDR_W'(NUM_CARDS));
                check_done    <= 1'b1;
            end
        end
    end

endmodule

//--- memory_game_core.sv
`timescale 1ns/10ps

module memory_game_core (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              deal,
    input  logic [card_pkg::CARD_ADDR_W-1:0]  deal_seed,
    input  logic                              pick,
    input  logic [card_pkg::CARD_ADDR_W-1:0]  pick_addr,
    input  logic                              check,
    output logic                              deal_busy,
    output logic                              flip_busy,
    output logic                              match,
    output logic                              miss,
    output logic [card_pkg::CARD_ADDR_W-1:0]  matched_count,
    output logic                              all_matched,
    output logic                              check_done
);
    import card_pkg::*;

    // Write source 1, dealer
    logic                   wr1_en;
    logic [CARD_ADDR_W-1:0] wr1_addr;
    logic [IMAGE_W-1:0]     wr1_image;
    card_state_t            wr1_state;

    // Write source 2, flip logic
    logic                   wr2_en;
    logic [CARD_ADDR_W-1:0] wr2_addr;
    card_state_t            wr2_state;

    // Register file port
    logic                   rf_wen_full;
    logic                   rf_wen_state;
    logic [CARD_ADDR_W-1:0] rf_waddr;
    logic [RECORD_W-1:0]    rf_wdata;
    logic [CARD_ADDR_W-1:0] rf_raddr;
    logic [RECORD_W-1:0]    rf_rdata;

    logic [CARD_ADDR_W-1:0] one_addr;
    logic                   sweep_busy;

    card_dealer u_dealer (
        .clk       (clk),
        .rst       (rst),
        .deal      (deal),
        .deal_seed (deal_seed),
        .wr1_en    (wr1_en),
        .wr1_addr  (wr1_addr),
        .wr1_image (wr1_image),
        .wr1_state (wr1_state),
        .deal_busy (deal_busy)
    );

    card_flip_logic u_flip (
        .clk        (clk),
        .rst        (rst),
        .pick       (pick),
        .pick_addr  (pick_addr),
        .deal_busy  (deal_busy),
        .sweep_busy (sweep_busy),
        .rd_data    (rf_rdata),
        .one_addr   (one_addr),
        .wr2_en     (wr2_en),
        .wr2_addr   (wr2_addr),
        .wr2_state  (wr2_state),
        .flip_busy  (flip_busy),
        .match      (match),
        .miss       (miss)
    );

    card_regfile_ctl u_ctl (
        .clk          (clk),
        .rst          (rst),
        .check        (check),
        .one_addr     (one_addr),
        .wr1_en       (wr1_en),
        .wr1_addr     (wr1_addr),
        .wr1_image    (wr1_image),
        .wr1_state    (wr1_state),
        .wr2_en       (wr2_en),
        .wr2_addr     (wr2_addr),
        .wr2_state    (wr2_state),
        .rf_wen_full  (rf_wen_full),
        .rf_wen_state (rf_wen_state),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .rf_raddr     (rf_raddr),
        .sweep_busy   (sweep_busy)
    );

    card_regfile u_regfile (
        .clk       (clk),
        .rst       (rst),
        .wen_full  (rf_wen_full),
        .wen_state (rf_wen_state),
        .waddr     (rf_waddr),
        .wdata     (rf_wdata),
        .raddr     (rf_raddr),
        .rdata     (rf_rdata)
    );

    // Same read data feeds the sweep counter
    card_scan u_scan (
        .clk           (clk),
        .rst           (rst),
        .sweep_busy    (sweep_busy),
        .rd_data       (rf_rdata),
        .matched_count (matched_count),
        .all_matched   (all_matched),
        .check_done    (check_done)
    );

endmodule

//--- tb_memory_game.sv
`timescale 1ns/10ps

module tb_memory_game;
    import card_pkg::*;

    localparam int WAIT_LIMIT = 200;
    localparam int NUM_ROUNDS = 4;

    logic                   clk;
    logic                   rst;
    logic                   deal;
    logic [CARD_ADDR_W-1:0] deal_seed;
    logic                   pick;
    logic [CARD_ADDR_W-1:0] pick_addr;
    logic                   check;
    logic                   deal_busy;
    logic                   flip_busy;
    logic                   match;
    logic                   miss;
    logic [CARD_ADDR_W-1:0] matched_count;
    logic                   all_matched;
    logic                   check_done;

    // Expected state of every card, and the seed of the current deal
    card_state_t model_state [FIRST_CARD:NUM_CARDS];
    int          cur_seed;
    logic [31:0] rng;
    int          errors;
    int          timeouts;
    int          checks;
    int          monitor_errors = 0;

    memory_game_core DUT (
        .clk           (clk),
        .rst           (rst),
        .deal          (deal),
        .deal_seed     (deal_seed),
        .pick          (pick),
        .pick_addr     (pick_addr),
        .check         (check),
        .deal_busy     (deal_busy),
        .flip_busy     (flip_busy),
        .match         (match),
        .miss          (miss),
        .matched_count (matched_count),
        .all_matched   (all_matched),
        .check_done    (check_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Two neighbouring rotated slots share a pair
    function automatic int pair_of(input int k, input int seed);
        return ((k - 1 + seed % NUM_CARDS) % NUM_CARDS) / 2;
    endfunction

    // Address of the first or second card of a pair
    function automatic int card_of(input int pair, input int nth);
        int seen;
        int found;
        seen  = 0;
        found = 0;
        for (int k = FIRST_CARD; k <= NUM_CARDS; k++) begin
            if (pair_of(k, cur_seed) == pair) begin
                if (seen == nth) begin
                    found = k;
                end
                seen++;
            end
        end
        return found;
    endfunction

    function automatic int model_matched();
        int n;
        n = 0;
        for (int k = FIRST_CARD; k <= NUM_CARDS; k++) begin
            if (model_state[k] == CARD_MATCHED) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic compare_value(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout: %s did not finish within %0d cycles", what, WAIT_LIMIT);
    endtask

    //////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////

    // Deal and count busy cycles with an optional stray pick in the first busy cycle
    task automatic run_deal(input string name, input int seed, input int stray);
        int busy_cycles;
        @(negedge clk);
        deal      = 1'b1;
        deal_seed = CARD_ADDR_W'(seed);
        @(negedge clk);
        deal = 1'b0;
        if (stray != 0) begin
            pick      = 1'b1;
            pick_addr = CARD_ADDR_W'(stray);
        end
        busy_cycles = 0;
        while (deal_busy && busy_cycles < WAIT_LIMIT) begin
            @(negedge clk);
            busy_cycles++;
            pick = 1'b0;
            if (stray != 0 && busy_cycles == 1) begin
                compare_value({name, " flip_busy after stray pick"}, 0, int'(flip_busy));
            end
        end
        if (deal_busy) begin
            report_timeout({name, " deal"});
        end
        compare_value({name, " deal_busy cycles"}, NUM_CARDS, busy_cycles);
        cur_seed = seed;
        for (int k = FIRST_CARD; k <= NUM_CARDS; k++) begin
            model_state[k] = CARD_HIDDEN;
        end
    endtask

    // Pick one card and collect the pulses until flip_busy is low
    task automatic flip_card(input int addr, output logic saw_match, output logic saw_miss);
        int guard;
        @(negedge clk);
        pick      = 1'b1;
        pick_addr = CARD_ADDR_W'(addr);
        @(negedge clk);
        pick      = 1'b0;
        saw_match = match;
        saw_miss  = miss;
        guard     = 0;
        while (flip_busy && guard < WAIT_LIMIT) begin
            @(negedge clk);
            guard++;
            saw_match = saw_match | match;
            saw_miss  = saw_miss | miss;
        end
        if (flip_busy) begin
            report_timeout($sformatf("flip of card %0d", addr));
        end
    endtask

    task automatic play_pair(input string name, input int a, input int b);
        logic got_match;
        logic got_miss;
        logic exp_match;
        logic exp_miss;
        flip_card(a, got_match, got_miss);
        compare_value({name, " first match"}, 0, int'(got_match));
        compare_value({name, " first miss"}, 0, int'(got_miss));
        // A card that is not face down is dropped without a second step
        if (model_state[a] == CARD_HIDDEN) begin
            model_state[a] = CARD_SHOWN;
            exp_match = 1'b0;
            exp_miss  = 1'b0;
            if (b != a && model_state[b] == CARD_HIDDEN) begin
                exp_match = (CARD_IMAGES[pair_of(a, cur_seed)] ==
                             CARD_IMAGES[pair_of(b, cur_seed)]);
                exp_miss  = !exp_match;
            end
            flip_card(b, got_match, got_miss);
            compare_value({name, " match"}, int'(exp_match), int'(got_match));
            compare_value({name, " miss"}, int'(exp_miss), int'(got_miss));
            if (exp_match) begin
                model_state[a] = CARD_MATCHED;
                model_state[b] = CARD_MATCHED;
            end else if (exp_miss) begin
                model_state[a] = CARD_HIDDEN;
                model_state[b] = CARD_HIDDEN;
            end
        end
    endtask

    // Sweep the board with an optional stray pick while the sweep runs
    task automatic sweep_check(input string name, input int stray);
        int guard;
        int exp_count;
        @(negedge clk);
        check = 1'b1;
        @(negedge clk);
        check = 1'b0;
        if (stray != 0) begin
            pick      = 1'b1;
            pick_addr = CARD_ADDR_W'(stray);
        end
        guard = 0;
        while (!check_done && guard < WAIT_LIMIT) begin
            @(negedge clk);
            guard++;
            pick = 1'b0;
            if (stray != 0 && guard == 1) begin
                compare_value({name, " flip_busy after stray pick"}, 0, int'(flip_busy));
            end
        end
        if (!check_done) begin
            report_timeout({name, " sweep"});
        end else begin
            exp_count = model_matched();
            compare_value({name, " matched_count"}, exp_count, int'(matched_count));
            compare_value({name, " all_matched"}, int'(exp_count == NUM_CARDS),
                          int'(all_matched));
        end
    endtask

    // Match all six pairs in a shuffled order
    task automatic clear_board(input string name);
        int order [NUM_PAIRS];
        int j;
        int tmp;
        int nth;
        for (int i = 0; i < NUM_PAIRS; i++) begin
            order[i] = i;
        end
        for (int i = NUM_PAIRS - 1; i > 0; i--) begin
            rng      = next_random(rng);
            j        = int'(rng % 32'(i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < NUM_PAIRS; i++) begin
            rng = next_random(rng);
            nth = int'(rng[0]);
            play_pair($sformatf("%s pair %0d", name, order[i]),
                      card_of(order[i], nth), card_of(order[i], 1 - nth));
        end
    endtask

    //////////////////////////////////////////////////
    // Output monitor
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst) begin
            assert (!(match && miss)) else begin
                monitor_errors++;
                $display("Match and miss are both high at %0t", $time);
            end
        end
    end

    initial begin
        rst       = 1'b1;
        deal      = 1'b0;
        deal_seed = '0;
        pick      = 1'b0;
        pick_addr = '0;
        check     = 1'b0;
        rng       = 32'ha21f_59af;
        errors    = 0;
        timeouts  = 0;
        checks    = 0;
        cur_seed  = 0;
        for (int k = FIRST_CARD; k <= NUM_CARDS; k++) begin
            model_state[k] = CARD_HIDDEN;
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // Idle outputs after reset
        compare_value("reset deal_busy", 0, int'(deal_busy));
        compare_value("reset flip_busy", 0, int'(flip_busy));
        compare_value("reset match", 0, int'(match));
        compare_value("reset miss", 0, int'(miss));
        compare_value("reset matched_count", 0, int'(matched_count));
        compare_value("reset all_matched", 0, int'(all_matched));
        compare_value("reset check_done", 0, int'(check_done));

        rng = next_random(rng);
        run_deal("first deal", int'(rng[3:0]), 0);
        sweep_check("empty board", 0);

        // One good pair, then a bad one twice
        play_pair("matching pair", card_of(0, 0), card_of(0, 1));
        sweep_check("one pair", 0);
        play_pair("mismatch", card_of(1, 0), card_of(2, 0));
        sweep_check("after mismatch", 0);
        play_pair("mismatch again", card_of(1, 0), card_of(2, 0));

        // Dropped and ignored picks
        play_pair("matched card", card_of(0, 0), card_of(1, 1));
        sweep_check("pick in sweep", card_of(1, 0));
        play_pair("after sweep pick", card_of(1, 0), card_of(1, 1));
        sweep_check("two pairs", 0);
        rng = next_random(rng);
        run_deal("deal with pick", int'(rng[3:0]), card_of(3, 0));
        sweep_check("fresh board", 0);

        // Full games over several seeds
        for (int r = 0; r < NUM_ROUNDS; r++) begin
            rng = next_random(rng);
            run_deal($sformatf("round %0d", r), int'(rng[3:0]), 0);
            clear_board($sformatf("round %0d", r));
            sweep_check($sformatf("round %0d final", r), 0);
        end

        $display("Checks: %0d, errors: %0d, timeouts: %0d, monitor errors: %0d",
                 checks, errors, timeouts, monitor_errors);
        if (errors == 0 && timeouts == 0 && monitor_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
card_pkg.sv
card_regfile_ctl.sv
card_regfile.sv
card_dealer.sv
card_flip_logic.sv
card_scan.sv
memory_game_core.sv
tb_memory_game.sv

//--- run.sh
#!/bin/sh
# Build and run the memory game testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --top-module tb_memory_game \
    -f filelist.f -o sim_memory_game > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_memory_game > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$SIM_LOG"; then
    exit 1
fi
exit 0
